// ==== hdl/mctrl_consts.svh ====
`ifndef MCTRL_CONSTS_SVH
`define MCTRL_CONSTS_SVH

//----------------------------------------------------------------------
// uplink cache sizing
//----------------------------------------------------------------------
`define CACHE_DEPTH      32768          // words per uplink cache
`define CACHE_HALF       16384          // fill level that triggers a cache report

`define SLOT_CYCLES_DEF  (1 << 24)      // default slot length, ~0.1 s at 163.84 MHz

//----------------------------------------------------------------------
// frame format
//----------------------------------------------------------------------
`define FRAME_HDR        8'hEB          // sync byte, outside the crc
`define CRC8_POLY        8'h07          // x^8 + x^2 + x + 1

// report type codes
`define PT_DS_SYNC       8'h20          // downlink sync data
`define PT_MSLS          8'h21          // medium/low speed status
`define PT_DS_STAT       8'h22          // downlink statistics
`define PT_US_STAT       8'h23          // uplink statistics
`define PT_CACHE         8'h24          // uplink cache remaining space
`define PT_SW            8'h30          // software version

// information unit ids
`define IU_DOWN          8'd40
`define IU_UP            8'd41
`define IU_SW            8'd42

// payload length in bytes, per report type
`define LEN_DS_SYNC      13
`define LEN_MSLS         5
`define LEN_STAT         8              // both statistics reports
`define LEN_CACHE        6
`define LEN_SW           4

`endif

// ==== hdl/mctrl_pkg.sv ====
package mctrl_pkg;

    //------------------------------------------------------------------
    // width types
    //------------------------------------------------------------------
    typedef logic [7:0]  para_type_t;   // report type code
    typedef logic [7:0]  info_id_t;     // information unit id
    typedef logic [15:0] cache_cnt_t;   // one cache fill / remaining count
    typedef logic [7:0]  byte_t;

    //------------------------------------------------------------------
    // modem status snapshot, 352 bits
    //------------------------------------------------------------------
    typedef struct packed {
        logic [103:0]     ds_sync;      // 0x20
        logic [39:0]      ms_ls;        // 0x21
        logic [63:0]      ds_stat;      // 0x22, cut down to 64 bits
        logic [63:0]      us_stat;      // 0x23, cut down to 64 bits
        cache_cnt_t [2:0] cache_cnt;    // [2] control, [1] business, [0] circuit
        logic [31:0]      sw_info;      // 0x30
    } status_t;

    // report request, 9 bits
    // a one cycle strobe on every link that carries it
    typedef struct packed {
        logic       valid;
        para_type_t ptype;
    } report_req_t;

    // serial transmitter phases
    typedef enum logic [1:0] {
        IDLE = 2'd0,    // waiting for a grant
        HDR  = 2'd1,    // sync, id, type, length
        BODY = 2'd2,    // payload bytes
        CRC  = 2'd3     // trailing crc-8
    } tx_state_e;

endpackage

// ==== hdl/report_scheduler.sv ====
`timescale 1ns/1ps
`include "mctrl_consts.svh"

module report_scheduler import mctrl_pkg::*; #(
    parameter int unsigned SLOT_CYCLES = `SLOT_CYCLES_DEF
) (
    input  logic             i_clk163m84,
    input  logic             i_rst_n,
    input  logic             i_report_en,    // gates every periodic report
    input  cache_cnt_t [2:0] i_cache_cnt,    // live fill counts
    output report_req_t      o_per_req,      // one cycle strobe
    output cache_cnt_t [2:0] o_cache_remain  // free space, one cycle late
);

    localparam int CNT_W = (SLOT_CYCLES > 1) ? $clog2(SLOT_CYCLES) : 1;

    logic [CNT_W-1:0] slot_cnt;
    logic [1:0]       slot_idx;  // four slots per period
    logic             slot_wrap;
    logic             half_hit;  // some cache at least half full
    report_req_t      sched_req;

    assign slot_wrap = (slot_cnt == CNT_W'(SLOT_CYCLES - 1));

    //------------------------------------------------------------------
    // slot timer
    //------------------------------------------------------------------
    always_ff @(posedge i_clk163m84 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            slot_cnt <= '0;
            slot_idx <= 2'd0;
        end else if (slot_wrap) begin
            slot_cnt <= '0;
            slot_idx <= slot_idx + 2'd1;  // 3 -> 0 rolls over
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    always_comb begin
        half_hit = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (i_cache_cnt[i] >= cache_cnt_t'(`CACHE_HALF))
                half_hit = 1'b1;
        end
    end

    // schedule table, looked up only at the first cycle of a slot
    always_comb begin
        sched_req = '0;
        if (slot_cnt == '0 && i_report_en) begin
            case (slot_idx)
                2'd1: sched_req = '{valid: 1'b1, ptype: `PT_DS_STAT};
                2'd3: sched_req = '{valid: 1'b1, ptype: `PT_US_STAT};
                default: begin                    // slots 0 and 2
                    if (half_hit)
                        sched_req = '{valid: 1'b1, ptype: `PT_CACHE};
                end
            endcase
        end
    end

    always_ff @(posedge i_clk163m84 or negedge i_rst_n) begin
        if (!i_rst_n)
            o_per_req <= '0;
        else
            o_per_req <= sched_req;  // strobe drops next cycle
    end

    // remaining space, free running
    always_ff @(posedge i_clk163m84) begin
        for (int i = 0; i < 3; i++)
            o_cache_remain[i] <= cache_cnt_t'(`CACHE_DEPTH) - i_cache_cnt[i];
    end

endmodule

// ==== hdl/report_arbiter.sv ====
`timescale 1ns/1ps
`include "mctrl_consts.svh"

module report_arbiter import mctrl_pkg::*; (
    input  logic        i_clk163m84,
    input  logic        i_rst_n,
    input  logic        i_host_req,   // strobe
    input  para_type_t  i_host_type,
    input  report_req_t i_per_req,    // periodic strobe from scheduler
    input  logic        i_tx_busy,
    output report_req_t o_grant       // one cycle strobe to transmitter
);

    logic       host_pend;
    logic       per_pend;
    para_type_t host_type_q;
    para_type_t per_type_q;
    logic       host_ok;
    logic       can_grant;
    logic       gnt_host;
    logic       gnt_per;

    // supported report codes
    function automatic logic type_ok(input para_type_t t);
        case (t)
            `PT_DS_SYNC, `PT_MSLS, `PT_DS_STAT,
            `PT_US_STAT, `PT_CACHE, `PT_SW: type_ok = 1'b1;
            default:                        type_ok = 1'b0;
        endcase
    endfunction

    assign host_ok   = i_host_req && type_ok(i_host_type);  // bad codes dropped here
    assign can_grant = !i_tx_busy && !o_grant.valid;        // busy rises a cycle after grant
    assign gnt_host  = can_grant && host_pend;              // host wins
    assign gnt_per   = can_grant && !host_pend && per_pend;

    always_ff @(posedge i_clk163m84 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            host_pend <= 1'b0;
            per_pend  <= 1'b0;
            o_grant   <= '0;
        end else begin
            if (gnt_host) host_pend <= 1'b0;
            if (host_ok)  host_pend <= 1'b1;     // new arrival outranks the clear
            if (gnt_per)  per_pend  <= 1'b0;
            if (i_per_req.valid) per_pend <= 1'b1;
            o_grant.valid <= gnt_host || gnt_per;
            o_grant.ptype <= gnt_host ? host_type_q : per_type_q;
        end
    end

    // latest type per source, older one overwritten
    always_ff @(posedge i_clk163m84) begin
        if (host_ok)
            host_type_q <= i_host_type;
        if (i_per_req.valid)
            per_type_q <= i_per_req.ptype;
    end

endmodule

// ==== hdl/frame_tx.sv ====
`timescale 1ns/1ps
`include "mctrl_consts.svh"

module frame_tx import mctrl_pkg::*; (
    input  logic             i_clk163m84,
    input  logic             i_rst_n,
    input  report_req_t      i_grant,
    input  status_t          i_status,
    input  cache_cnt_t [2:0] i_cache_remain,
    output logic             o_tx_busy,
    output logic             o_tx_data,   // msb first
    output logic             o_tx_en
);

    localparam int PAY_W = `LEN_DS_SYNC * 8;  // longest payload

    tx_state_e        state;
    logic [2:0]       bit_cnt;
    logic [3:0]       byte_idx;
    byte_t            cur_byte;     // byte on the wire
    byte_t            crc_q;
    logic [PAY_W-1:0] pay_buf;      // left aligned and shifted a byte at a time
    para_type_t       type_q;
    info_id_t         id_q;
    logic [3:0]       len_q;
    info_id_t         lk_id;
    logic [3:0]       lk_len;
    logic [PAY_W-1:0] lk_pay;
    logic             start;
    logic             byte_end;
    logic             last_body;
    byte_t            nxt_byte;
    logic             nxt_is_crc;
    logic             take_pay;

    function automatic byte_t crc8_upd(input byte_t crc, input byte_t data);
        byte_t c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++)
            c = c[7] ? ((c << 1) ^ `CRC8_POLY) : (c << 1);
        return c;
    endfunction

    assign start     = (state == IDLE) && i_grant.valid;
    assign byte_end  = (state != IDLE) && (bit_cnt == 3'd7);
    assign last_body = (byte_idx == len_q - 4'd1);

    //------------------------------------------------------------------
    // per type lookup with the payload padded to the left
    //------------------------------------------------------------------
    always_comb begin
        case (i_grant.ptype)
            `PT_DS_SYNC: begin
                lk_id  = `IU_DOWN;
                lk_len = 4'(`LEN_DS_SYNC);
                lk_pay = i_status.ds_sync;
            end
            `PT_MSLS: begin
                lk_id  = `IU_UP;
                lk_len = 4'(`LEN_MSLS);
                lk_pay = {i_status.ms_ls, 64'd0};
            end
            `PT_DS_STAT: begin
                lk_id  = `IU_DOWN;
                lk_len = 4'(`LEN_STAT);
                lk_pay = {i_status.ds_stat, 40'd0};
            end
            `PT_US_STAT: begin
                lk_id  = `IU_UP;
                lk_len = 4'(`LEN_STAT);
                lk_pay = {i_status.us_stat, 40'd0};
            end
            `PT_CACHE: begin
                lk_id  = `IU_UP;
                lk_len = 4'(`LEN_CACHE);
                lk_pay = {i_cache_remain, 56'd0};
            end
            default: begin
                lk_id  = `IU_SW;
                lk_len = 4'(`LEN_SW);
                lk_pay = {i_status.sw_info, 72'd0};
            end
        endcase
    end

    // next byte to load when the current one finishes
    always_comb begin
        nxt_byte   = crc_q;
        nxt_is_crc = 1'b1;
        take_pay   = 1'b0;
        case (state)
            HDR: begin
                nxt_is_crc = 1'b0;
                case (byte_idx)
                    4'd0:    nxt_byte = id_q;
                    4'd1:    nxt_byte = type_q;
                    4'd2:    nxt_byte = {4'd0, len_q};
                    default: begin
                        nxt_byte = pay_buf[PAY_W-1 -: 8];  // first payload byte
                        take_pay = 1'b1;
                    end
                endcase
            end
            BODY: begin
                if (!last_body) begin
                    nxt_byte   = pay_buf[PAY_W-1 -: 8];
                    nxt_is_crc = 1'b0;
                    take_pay   = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // snapshot and byte datapath with the crc folded in as each byte loads
    always_ff @(posedge i_clk163m84) begin
        if (start) begin
            type_q   <= i_grant.ptype;
            id_q     <= lk_id;
            len_q    <= lk_len;
            pay_buf  <= lk_pay;
            cur_byte <= `FRAME_HDR;
            crc_q    <= '0;                // init 0 and the sync byte excluded
        end else if (byte_end) begin
            cur_byte <= nxt_byte;
            if (!nxt_is_crc)
                crc_q <= crc8_upd(crc_q, nxt_byte);
            if (take_pay)
                pay_buf <= {pay_buf[PAY_W-9:0], 8'h00};
        end
    end

    //------------------------------------------------------------------
    // fsm and serial output
    //------------------------------------------------------------------
    always_ff @(posedge i_clk163m84 or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= IDLE;
            bit_cnt   <= 3'd0;
            byte_idx  <= 4'd0;
            o_tx_busy <= 1'b0;
            o_tx_en   <= 1'b0;
            o_tx_data <= 1'b0;
        end else if (state == IDLE) begin
            o_tx_en   <= 1'b0;
            o_tx_data <= 1'b0;
            o_tx_busy <= start;            // falls together with o_tx_en
            if (start) begin
                state    <= HDR;
                bit_cnt  <= 3'd0;
                byte_idx <= 4'd0;
            end
        end else begin
            o_tx_en   <= 1'b1;
            o_tx_data <= cur_byte[3'd7 - bit_cnt];
            bit_cnt   <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                case (state)
                    HDR: begin
                        byte_idx <= (byte_idx == 4'd3) ? 4'd0 : byte_idx + 4'd1;
                        if (byte_idx == 4'd3)
                            state <= BODY;
                    end
                    BODY: begin
                        byte_idx <= byte_idx + 4'd1;
                        if (last_body)
                            state <= CRC;
                    end
                    default: state <= IDLE;  // crc byte done
                endcase
            end
        end
    end

endmodule

// ==== hdl/mctrl_top.sv ====
`timescale 1ns/1ps
`include "mctrl_consts.svh"

module mctrl_top import mctrl_pkg::*; #(
    parameter int unsigned SLOT_CYCLES = `SLOT_CYCLES_DEF
) (
    input  logic       i_clk163m84,
    input  logic       i_rst_n,
    input  status_t    i_status,     // held by the modem side
    input  logic       i_report_en,
    input  logic       i_host_req,   // strobe
    input  para_type_t i_host_type,
    output logic       o_tx_data,
    output logic       o_tx_en
);

    report_req_t      per_req;       // periodic request strobe
    cache_cnt_t [2:0] cache_remain;
    report_req_t      grant;
    logic             tx_busy;

    //------------------------------------------------------------------
    // requesters
    //------------------------------------------------------------------
    report_scheduler #(
        .SLOT_CYCLES    (SLOT_CYCLES)
    ) u_sched (
        .i_clk163m84    (i_clk163m84),
        .i_rst_n        (i_rst_n),
        .i_report_en    (i_report_en),
        .i_cache_cnt    (i_status.cache_cnt),
        .o_per_req      (per_req),
        .o_cache_remain (cache_remain)
    );

    // host before periodic
    report_arbiter u_arb (
        .i_clk163m84    (i_clk163m84),
        .i_rst_n        (i_rst_n),
        .i_host_req     (i_host_req),
        .i_host_type    (i_host_type),
        .i_per_req      (per_req),
        .i_tx_busy      (tx_busy),
        .o_grant        (grant)
    );

    //------------------------------------------------------------------
    // shared serial transmitter
    //------------------------------------------------------------------
    frame_tx u_tx (
        .i_clk163m84    (i_clk163m84),
        .i_rst_n        (i_rst_n),
        .i_grant        (grant),
        .i_status       (i_status),
        .i_cache_remain (cache_remain),
        .o_tx_busy      (tx_busy),
        .o_tx_data      (o_tx_data),
        .o_tx_en        (o_tx_en)
    );

endmodule

// ==== test/mctrl_chk.sv ====
`timescale 1ns/1ps

module mctrl_chk (
    input logic i_clk163m84,
    input logic i_rst_n,
    input logic i_grant_vld,
    input logic i_tx_busy,
    input logic i_tx_en
);

    // one transmitter and no grant while it is working
    a_grant_idle: assert property (@(posedge i_clk163m84) disable iff (!i_rst_n)
        i_grant_vld |-> !i_tx_busy)
        else $error("grant issued while transmitter busy");

    a_en_in_busy: assert property (@(posedge i_clk163m84) disable iff (!i_rst_n)
        !i_tx_busy |-> !i_tx_en)
        else $error("tx enable high outside a frame");

    // enable only drops at the end of the frame
    a_en_one_gap: assert property (@(posedge i_clk163m84) disable iff (!i_rst_n)
        $fell(i_tx_en) |-> !i_tx_busy)
        else $error("tx enable dropped inside a frame");

endmodule

bind frame_tx mctrl_chk u_chk_tx (
    .i_clk163m84 (i_clk163m84),
    .i_rst_n     (i_rst_n),
    .i_grant_vld (i_grant.valid),
    .i_tx_busy   (o_tx_busy),
    .i_tx_en     (o_tx_en)
);

// ==== test/mctrl_tb.sv ====
`timescale 1ns/1ps
`include "mctrl_consts.svh"

module mctrl_tb import mctrl_pkg::*; ();

    localparam int SLOT = 64;        // short slots for simulation
    localparam int MAX_B = 17;       // longest frame before its crc

    logic       i_clk163m84 = 1'b0;
    logic       i_rst_n;
    status_t    status;
    logic       report_en;
    logic       host_req;
    para_type_t host_type;
    logic       tx_data;
    logic       tx_en;

    // steps and frames as read from the data file
    logic [47:0]        st_cc[$];
    logic               st_en[$];
    logic               st_hreq[$];
    para_type_t         st_htype[$];
    int                 st_wait[$];
    int                 st_nfr[$];
    int                 fr_len[$];
    logic [8*MAX_B-1:0] fr_val[$];
    // frames owed by the DUT, in order
    int                 exp_len[$];
    logic [8*MAX_B-1:0] exp_val[$];

    byte_t rx_bytes[$];              // decoded bytes of the frame on the wire
    byte_t shreg = '0;
    int    rx_bits = 0;
    logic  in_frame = 1'b0;
    logic  stim_loaded = 1'b0;
    int    watchdog_cycles = 0;

    always #4 i_clk163m84 = ~i_clk163m84;   // 8 ns period

    mctrl_top #(.SLOT_CYCLES(SLOT)) DUT (
        .i_clk163m84 (i_clk163m84),
        .i_rst_n     (i_rst_n),
        .i_status    (status),
        .i_report_en (report_en),
        .i_host_req  (host_req),
        .i_host_type (host_type),
        .o_tx_data   (tx_data),
        .o_tx_en     (tx_en)
    );

    //------------------------------------------------------------------
    // failure reporting
    //------------------------------------------------------------------
    task automatic stop_on_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
            stop_on_failure();
        end
    endtask

    // crc-8, poly x^8+x^2+x+1, one bit at a time msb first
    function automatic byte_t crc8_ref(input byte_t crc, input byte_t b);
        byte_t c;
        logic  fb;
        c = crc;
        for (int k = 7; k >= 0; k--) begin
            fb = c[7] ^ b[k];
            c  = {c[6:0], 1'b0};
            if (fb)
                c = c ^ `CRC8_POLY;
        end
        return c;
    endfunction

    task automatic load_stim();
        int    fd;
        string line;
        int    c2, c1, c0, en, hr, ht, w, len;
        logic [8*MAX_B-1:0] val;
        logic [103:0] ds_sync;
        logic [63:0]  ds_stat, us_stat;
        logic [39:0]  ms_ls;
        logic [31:0]  sw;
        fd = $fopen("test/mctrl_stim.txt", "r");
        if (fd == 0)
            abort_run("cannot open test/mctrl_stim.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0)
                continue;
            case (line.getc(0))
                "S": begin                     // fixed status words
                    void'($sscanf(line, "S %h %h %h %h %h",
                                  ds_sync, ms_ls, ds_stat, us_stat, sw));
                    status.ds_sync = ds_sync;
                    status.ms_ls   = ms_ls;
                    status.ds_stat = ds_stat;
                    status.us_stat = us_stat;
                    status.sw_info = sw;
                end
                "T": begin
                    void'($sscanf(line, "T %h %h %h %h %h %h %d", c2, c1, c0, en, hr, ht, w));
                    st_cc.push_back({16'(c2), 16'(c1), 16'(c0)});
                    st_en.push_back(en[0]);
                    st_hreq.push_back(hr[0]);
                    st_htype.push_back(8'(ht));
                    st_wait.push_back(w);
                    st_nfr.push_back(0);
                    watchdog_cycles += w;
                end
                "F": begin                     // belongs to the last step
                    void'($sscanf(line, "F %d %h", len, val));
                    fr_len.push_back(len);
                    fr_val.push_back(val);
                    st_nfr[st_nfr.size()-1]++;
                end
                default: ;                     // comment line
            endcase
        end
        $fclose(fd);
    endtask

    //------------------------------------------------------------------
    // serial decoder, sampled mid cycle
    //------------------------------------------------------------------
    task automatic end_frame();
        int                 n;
        logic [8*MAX_B-1:0] v;
        byte_t              b;
        byte_t              crc;
        if (rx_bits % 8 != 0)
            abort_run("frame on o_tx_data is not a whole number of bytes");
        if (exp_len.size() == 0)
            abort_run("unexpected frame on o_tx_data");
        n   = exp_len.pop_front();
        v   = exp_val.pop_front();
        crc = '0;
        check_value("frame length", n + 1, rx_bytes.size());
        for (int j = 0; j < n; j++) begin
            b = v[8*(n-1-j) +: 8];
            check_value($sformatf("o_tx_data byte %0d", j), b, rx_bytes[j]);
            if (j > 0)
                crc = crc8_ref(crc, b);        // sync byte not covered
        end
        check_value("o_tx_data crc byte", crc, rx_bytes[n]);
        rx_bytes.delete();
        rx_bits = 0;
    endtask

    always @(negedge i_clk163m84) begin
        if (tx_en) begin
            shreg = {shreg[6:0], tx_data};
            rx_bits++;
            if (rx_bits % 8 == 0)
                rx_bytes.push_back(shreg);
        end else if (in_frame) begin
            end_frame();
        end
        in_frame = tx_en;
    end

    // watchdog
    initial begin
        wait (stim_loaded);
        repeat (watchdog_cycles) @(posedge i_clk163m84);
        abort_run("watchdog timeout, the run did not finish in time");
    end

    //------------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------------
    initial begin
        i_rst_n   = 1'b0;
        status    = '0;
        report_en = 1'b0;
        host_req  = 1'b0;
        host_type = '0;
        load_stim();
        watchdog_cycles += 4 * SLOT + 2000 + 8;
        stim_loaded = 1'b1;
        repeat (3) @(posedge i_clk163m84);
        i_rst_n <= 1'b1;
        @(posedge i_clk163m84);
        for (int s = 0; s < st_wait.size(); s++) begin
            status.cache_cnt <= st_cc[s];
            report_en        <= st_en[s];
            host_req         <= st_hreq[s];
            host_type        <= st_htype[s];
            for (int f = 0; f < st_nfr[s]; f++) begin
                exp_len.push_back(fr_len.pop_front());
                exp_val.push_back(fr_val.pop_front());
            end
            @(posedge i_clk163m84);
            host_req <= 1'b0;                  // one cycle strobe
            repeat (st_wait[s] - 1) @(posedge i_clk163m84);
            if (exp_len.size() != 0)
                abort_run($sformatf("step %0d ended with %0d expected frame(s) missing",
                                    s, exp_len.size()));
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== test/mctrl_stim.txt ====
# S ds_sync ms_ls ds_stat us_stat sw_info (hex, held for the whole run)
# T cc2 cc1 cc0 report_en host_req host_type wait_cycles ; F nbytes frame_hex (no crc)
S 0102030405060708090a0b0c0d a1a2a3a4a5 d0d1d2d3d4d5d6d7 e0e1e2e3e4e5e6e7 12345678
# idle after reset
T 0100 0200 0300 0 0 00 40
# host reports
T 0100 0200 0300 0 1 30 90
F 8 eb2a300412345678
T 0100 0200 0300 0 1 21 100
F 9 eb292105a1a2a3a4a5
T 0100 0200 0300 0 1 20 160
F 17 eb28200d0102030405060708090a0b0c0d
# unsupported host type
T 0100 0200 0300 0 1 55 20
# statistics schedule, caches below half
T 0100 0200 0300 1 0 00 289
F 12 eb292308e0e1e2e3e4e5e6e7
F 12 eb282208d0d1d2d3d4d5d6d7
# business cache at half
T 0100 4000 0300 1 0 00 180
F 12 eb292308e0e1e2e3e4e5e6e7
T 0100 4000 0300 0 0 00 200
F 10 eb2924067f0040007d00
F 12 eb282208d0d1d2d3d4d5d6d7
# host request during a periodic frame
T 0100 0200 0300 1 0 00 40
T 0100 0200 0300 1 1 30 220
F 12 eb282208d0d1d2d3d4d5d6d7
F 8 eb2a300412345678
T 0100 0200 0300 0 0 00 100
F 12 eb292308e0e1e2e3e4e5e6e7

// ==== list.f ====
+incdir+hdl
hdl/mctrl_pkg.sv
hdl/report_scheduler.sv
hdl/report_arbiter.sv
hdl/frame_tx.sv
hdl/mctrl_top.sv
test/mctrl_chk.sv
test/mctrl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module mctrl_tb -f list.f -o mctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/mctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0
